//--- verilog/isa_pkg.sv
package isa_pkg;

    //////////////////////////////////////////////////
    // instruction encoding
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD    = 4'h0,
        OP_SUB    = 4'h1,
        OP_AND    = 4'h2,
        OP_OR     = 4'h3,
        OP_XOR    = 4'h4,
        OP_ADDI   = 4'h5,
        OP_TID    = 4'h6,
        OP_SETLT  = 4'h7,
        OP_STORE  = 4'h8,
        OP_FINISH = 4'h9
    } opcode_t;

    // 8 registers per thread per warp
    typedef logic [2:0] reg_addr_t;

    // wide enough for up to 8 warps
    typedef logic [2:0] warp_id_t;

    // opcode in the top nibble, immediate in the low 15 bits
    typedef struct packed {
        opcode_t    opcode;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [3:0] rsvd;
        logic [14:0] imm;
    } instr_t;

    // broadcast to every lane and the mask collector
    typedef struct packed {
        logic        issue;
        warp_id_t    warp;
        opcode_t     alu;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [31:0] imm;
        logic        reg_we;
        logic        store_en;
        logic        mask_set;
    } lane_op_t;

endpackage

//--- verilog/core_pkg.sv
package core_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    typedef logic [31:0] data_t;
    typedef logic [9:0]  imem_addr_t;
    typedef logic [11:0] dmem_addr_t;

    //////////////////////////////////////////////////
    // kernel launch and scheduling
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [2:0] num_warps;
        imem_addr_t base_addr;
    } kernel_cfg_t;

    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_PICK,
        SCHED_FETCH,
        SCHED_EXEC
    } sched_state_t;

    // one per thread, valid is a single-cycle pulse
    typedef struct packed {
        logic       valid;
        dmem_addr_t addr;
        data_t      data;
    } store_req_t;

endpackage

//--- verilog/warp_scheduler.sv
module warp_scheduler #(
    parameter int WARPS = 4
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           start,
    input  core_pkg::kernel_cfg_t                          cfg,
    input  logic                                           finish,
    output logic                                           done,
    output logic                                           imem_valid,
    output core_pkg::imem_addr_t                           imem_addr,
    input  logic                                           imem_ready,
    input  isa_pkg::instr_t                                imem_data,
    output isa_pkg::instr_t                                instr,
    output logic                                           exec,
    output logic [((WARPS > 1) ? $clog2(WARPS) : 1)-1:0]   warp
);
    import core_pkg::*;

    localparam int WW = (WARPS > 1) ? $clog2(WARPS) : 1;

    sched_state_t   state;
    imem_addr_t     pc [WARPS];
    logic [WARPS-1:0] warp_done;
    logic [WARPS-1:0] done_next;
    logic [WW-1:0]  next_warp;

    assign imem_valid = (state == SCHED_FETCH);
    assign imem_addr  = pc[warp];
    assign exec       = (state == SCHED_EXEC);

    // done flags including the instruction being issued now
    assign done_next = warp_done | (finish ? (WARPS'(1) << warp) : '0);

    // round robin, first live warp after the last one issued
    always_comb begin
        next_warp = warp;
        for (int i = WARPS; i >= 1; i--) begin
            if (!warp_done[(int'(warp) + i) % WARPS]) begin
                next_warp = WW'((int'(warp) + i) % WARPS);
            end
        end
    end

    //////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= SCHED_IDLE;
            done      <= 1'b0;
            warp      <= '0;
            warp_done <= '1;
            for (int w = 0; w < WARPS; w++) begin
                pc[w] <= '0;
            end
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (start) begin
                        done <= (cfg.num_warps == 3'd0);
                        warp <= WW'(WARPS - 1);
                        for (int w = 0; w < WARPS; w++) begin
                            warp_done[w] <= (w >= int'(cfg.num_warps));
                            pc[w]        <= cfg.base_addr;
                        end
                        if (cfg.num_warps != 3'd0) begin
                            state <= SCHED_PICK;
                        end
                    end
                end
                SCHED_PICK: begin
                    warp  <= next_warp;
                    state <= SCHED_FETCH;
                end
                SCHED_FETCH: begin
                    // latency set by the memory
                    if (imem_ready) begin
                        state <= SCHED_EXEC;
                    end
                end
                SCHED_EXEC: begin
                    pc[warp]  <= pc[warp] + 1'b1;
                    warp_done <= done_next;
                    if (&done_next) begin
                        done  <= 1'b1;
                        state <= SCHED_IDLE;
                    end else begin
                        state <= SCHED_PICK;
                    end
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    // fetched word, held through exec
    always_ff @(posedge clk) begin
        if (state == SCHED_FETCH && imem_ready) begin
            instr <= imem_data;
        end
    end

    // request held until the memory answers
    assert property (@(posedge clk) disable iff (!reset)
        imem_valid && !imem_ready |=> imem_valid);

endmodule

//--- verilog/instr_decoder.sv
module instr_decoder #(
    parameter int WARPS = 4
) (
    input  isa_pkg::instr_t                                instr,
    input  logic                                           exec,
    input  logic [((WARPS > 1) ? $clog2(WARPS) : 1)-1:0]   warp,
    output isa_pkg::lane_op_t                              op,
    output logic                                           finish
);
    import isa_pkg::*;

    assign finish = (instr.opcode == OP_FINISH);

    always_comb begin
        op        = '0;
        op.issue  = exec;
        op.warp   = warp_id_t'(warp);
        op.rd     = instr.rd;
        op.rs1    = instr.rs1;
        op.rs2    = instr.rs2;
        op.imm    = {{17{instr.imm[14]}}, instr.imm};
        op.alu    = OP_ADD;
        case (instr.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_TID: begin
                op.alu    = instr.opcode;
                op.reg_we = 1'b1;
            end
            OP_SETLT: begin
                op.alu      = OP_SETLT;
                op.mask_set = 1'b1;
            end
            // address comes from the immediate adder
            OP_STORE: begin
                op.alu      = OP_ADDI;
                op.store_en = 1'b1;
            end
            default: begin
                op.alu = OP_ADD;
            end
        endcase
    end

endmodule

//--- verilog/thread_lane.sv
module thread_lane #(
    parameter int WARPS   = 4,
    parameter int THREADS = 4,
    parameter int LANE_ID = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  isa_pkg::lane_op_t    op,
    input  logic                 mask_bit,
    output logic                 cmp_bit,
    output core_pkg::store_req_t store
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int WW = (WARPS > 1) ? $clog2(WARPS) : 1;

    data_t         regs [WARPS][8];
    logic [WW-1:0] w;
    data_t         a;
    data_t         b;
    data_t         result;
    logic          active;

    assign w      = op.warp[WW-1:0];
    assign active = op.issue && mask_bit;

    // r0 is hardwired to zero
    assign a = (op.rs1 == '0) ? '0 : regs[w][op.rs1];
    assign b = (op.rs2 == '0) ? '0 : regs[w][op.rs2];

    assign cmp_bit = ($signed(a) < $signed(b));

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (op.alu)
            OP_ADD:   result = a + b;
            OP_SUB:   result = a - b;
            OP_AND:   result = a & b;
            OP_OR:    result = a | b;
            OP_XOR:   result = a ^ b;
            OP_ADDI:  result = a + op.imm;
            OP_TID:   result = data_t'(op.warp) * THREADS + LANE_ID;
            default:  result = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (active && op.reg_we && op.rd != '0) begin
            regs[w][op.rd] <= result;
        end
    end

    // store request registered one cycle after exec
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            store <= '0;
        end else begin
            store.valid <= active && op.store_en;
            store.addr  <= result[11:0];
            store.data  <= b;
        end
    end

    // masked-off threads never store
    assert property (@(posedge clk) disable iff (!reset)
        store.valid |-> $past(op.issue && mask_bit));

endmodule

//--- verilog/lane_collector.sv
module lane_collector #(
    parameter int WARPS   = 4,
    parameter int THREADS = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  isa_pkg::lane_op_t  op,
    input  logic [THREADS-1:0] cmp_bits,
    output logic [THREADS-1:0] mask_bits
);
    localparam int WW = (WARPS > 1) ? $clog2(WARPS) : 1;

    logic [WARPS-1:0][THREADS-1:0] masks;
    logic [WW-1:0]                 w;

    assign w         = op.warp[WW-1:0];
    assign mask_bits = masks[w];

    // all threads live at launch
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            masks <= '1;
        end else if (start) begin
            masks <= '1;
        end else if (op.issue && op.mask_set) begin
            masks[w] <= cmp_bits;
        end
    end

    // masks only move on a launch or an issued SETLT
    assert property (@(posedge clk) disable iff (!reset)
        !start && !op.issue |=> $stable(masks));

endmodule

//--- verilog/simt_core.sv
module simt_core #(
    parameter int WARPS   = 4,
    parameter int THREADS = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  core_pkg::kernel_cfg_t                cfg,
    output logic                                 done,
    output logic                                 imem_valid,
    output core_pkg::imem_addr_t                 imem_addr,
    input  logic                                 imem_ready,
    input  isa_pkg::instr_t                      imem_data,
    output core_pkg::store_req_t [THREADS-1:0]   stores
);
    import isa_pkg::*;

    localparam int WW = (WARPS > 1) ? $clog2(WARPS) : 1;

    instr_t             instr;
    logic               exec;
    logic [WW-1:0]      warp;
    logic               finish;
    lane_op_t           op;
    logic [THREADS-1:0] cmp_bits;
    logic [THREADS-1:0] mask_bits;

    warp_scheduler #(.WARPS(WARPS)) u_sched (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cfg        (cfg),
        .finish     (finish),
        .done       (done),
        .imem_valid (imem_valid),
        .imem_addr  (imem_addr),
        .imem_ready (imem_ready),
        .imem_data  (imem_data),
        .instr      (instr),
        .exec       (exec),
        .warp       (warp)
    );

    instr_decoder #(.WARPS(WARPS)) u_dec (
        .instr  (instr),
        .exec   (exec),
        .warp   (warp),
        .op     (op),
        .finish (finish)
    );

    // identical lanes, one per thread of the running warp
    for (genvar t = 0; t < THREADS; t++) begin : g_lane
        thread_lane #(.WARPS(WARPS), .THREADS(THREADS), .LANE_ID(t)) u_lane (
            .clk      (clk),
            .reset    (reset),
            .op       (op),
            .mask_bit (mask_bits[t]),
            .cmp_bit  (cmp_bits[t]),
            .store    (stores[t])
        );
    end

    lane_collector #(.WARPS(WARPS), .THREADS(THREADS)) u_coll (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .op        (op),
        .cmp_bits  (cmp_bits),
        .mask_bits (mask_bits)
    );

endmodule

//--- bench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// one kernel launch and its slice of the expected list
typedef struct packed {
    logic [2:0] num_warps;
    imem_addr_t base;
    logic [7:0] first;
    logic [7:0] count;
} test_t;

typedef struct packed {
    dmem_addr_t addr;
    data_t      data;
} exp_word_t;

localparam int NUM_TESTS  = 4;
localparam int PROG_WORDS = 26;
localparam int NUM_EXP    = 62;

//////////////////////////////////////////////////
// kernels, all in one instruction memory
//////////////////////////////////////////////////

localparam instr_t PROGRAM [PROG_WORDS] = '{
    // thread number to 0x100 + tid
    '{OP_TID,    3'd1, 3'd0, 3'd0, 4'd0, 15'h0000},
    '{OP_STORE,  3'd0, 3'd1, 3'd1, 4'd0, 15'h0100},
    '{OP_FINISH, 3'd0, 3'd0, 3'd0, 4'd0, 15'h0000},
    // alu ops against 5, one region each
    '{OP_TID,    3'd1, 3'd0, 3'd0, 4'd0, 15'h0000},
    '{OP_ADDI,   3'd2, 3'd0, 3'd0, 4'd0, 15'h0005},
    '{OP_ADD,    3'd3, 3'd1, 3'd2, 4'd0, 15'h0000},
    '{OP_STORE,  3'd0, 3'd1, 3'd3, 4'd0, 15'h0200},
    '{OP_SUB,    3'd3, 3'd1, 3'd2, 4'd0, 15'h0000},
    '{OP_STORE,  3'd0, 3'd1, 3'd3, 4'd0, 15'h0210},
    // imm of -9
    '{OP_ADDI,   3'd4, 3'd1, 3'd0, 4'd0, 15'h7ff7},
    '{OP_AND,    3'd3, 3'd4, 3'd2, 4'd0, 15'h0000},
    '{OP_STORE,  3'd0, 3'd1, 3'd3, 4'd0, 15'h0220},
    '{OP_OR,     3'd3, 3'd4, 3'd2, 4'd0, 15'h0000},
    '{OP_STORE,  3'd0, 3'd1, 3'd3, 4'd0, 15'h0230},
    '{OP_XOR,    3'd3, 3'd4, 3'd2, 4'd0, 15'h0000},
    '{OP_STORE,  3'd0, 3'd1, 3'd3, 4'd0, 15'h0240},
    '{OP_STORE,  3'd0, 3'd1, 3'd4, 4'd0, 15'h0250},
    '{OP_FINISH, 3'd0, 3'd0, 3'd0, 4'd0, 15'h0000},
    // mask tid < 6, then 0 < 1 for everyone
    '{OP_TID,    3'd1, 3'd0, 3'd0, 4'd0, 15'h0000},
    '{OP_ADDI,   3'd2, 3'd0, 3'd0, 4'd0, 15'h0006},
    '{OP_ADDI,   3'd3, 3'd0, 3'd0, 4'd0, 15'h0001},
    '{OP_SETLT,  3'd0, 3'd1, 3'd2, 4'd0, 15'h0000},
    '{OP_STORE,  3'd0, 3'd1, 3'd1, 4'd0, 15'h0300},
    '{OP_SETLT,  3'd0, 3'd0, 3'd3, 4'd0, 15'h0000},
    '{OP_STORE,  3'd0, 3'd1, 3'd1, 4'd0, 15'h0310},
    '{OP_FINISH, 3'd0, 3'd0, 3'd0, 4'd0, 15'h0000}
};

localparam test_t TESTS [NUM_TESTS] = '{
    '{3'd4, 10'd0,  8'd0,  8'd16},
    '{3'd1, 10'd3,  8'd16, 8'd24},
    '{3'd4, 10'd18, 8'd40, 8'd22},
    // two warps give the first eight words of the first kernel
    '{3'd2, 10'd0,  8'd0,  8'd8}
};

localparam exp_word_t EXPECTED [NUM_EXP] = '{
    '{12'h100, 32'd0},  '{12'h101, 32'd1},  '{12'h102, 32'd2},  '{12'h103, 32'd3},
    '{12'h104, 32'd4},  '{12'h105, 32'd5},  '{12'h106, 32'd6},  '{12'h107, 32'd7},
    '{12'h108, 32'd8},  '{12'h109, 32'd9},  '{12'h10a, 32'd10}, '{12'h10b, 32'd11},
    '{12'h10c, 32'd12}, '{12'h10d, 32'd13}, '{12'h10e, 32'd14}, '{12'h10f, 32'd15},
    // tid + 5 and tid - 5
    '{12'h200, 32'd5},  '{12'h201, 32'd6},  '{12'h202, 32'd7},  '{12'h203, 32'd8},
    '{12'h210, -32'd5}, '{12'h211, -32'd4}, '{12'h212, -32'd3}, '{12'h213, -32'd2},
    // (tid - 9) and, or, xor 5
    '{12'h220, 32'd5},  '{12'h221, 32'd0},  '{12'h222, 32'd1},  '{12'h223, 32'd0},
    '{12'h230, -32'd9}, '{12'h231, -32'd3}, '{12'h232, -32'd3}, '{12'h233, -32'd1},
    '{12'h240, -32'd14}, '{12'h241, -32'd3}, '{12'h242, -32'd4}, '{12'h243, -32'd1},
    '{12'h250, -32'd9}, '{12'h251, -32'd8}, '{12'h252, -32'd7}, '{12'h253, -32'd6},
    // masked store, then all lanes back
    '{12'h300, 32'd0},  '{12'h301, 32'd1},  '{12'h302, 32'd2},  '{12'h303, 32'd3},
    '{12'h304, 32'd4},  '{12'h305, 32'd5},
    '{12'h310, 32'd0},  '{12'h311, 32'd1},  '{12'h312, 32'd2},  '{12'h313, 32'd3},
    '{12'h314, 32'd4},  '{12'h315, 32'd5},  '{12'h316, 32'd6},  '{12'h317, 32'd7},
    '{12'h318, 32'd8},  '{12'h319, 32'd9},  '{12'h31a, 32'd10}, '{12'h31b, 32'd11},
    '{12'h31c, 32'd12}, '{12'h31d, 32'd13}, '{12'h31e, 32'd14}, '{12'h31f, 32'd15}
};

`endif

//--- bench/simt_core_tb.sv
module simt_core_tb;
    import isa_pkg::*;
    import core_pkg::*;

    `include "tb_programs.svh"

    localparam int WARPS   = 4;
    localparam int THREADS = 4;

    logic                       clk = 1'b0;
    logic                       reset = 1'b0;
    logic                       start = 1'b0;
    kernel_cfg_t                cfg = '0;
    logic                       done;
    logic                       imem_valid;
    imem_addr_t                 imem_addr;
    logic                       imem_ready = 1'b0;
    instr_t                     imem_data = '0;
    store_req_t [THREADS-1:0]   stores;

    logic [31:0] rng_state = 32'h44d9_9b3f;
    int          delay_left = -1;
    logic        ready_seen = 1'b0;
    data_t       dmem [dmem_addr_t];
    int          store_count = 0;

    simt_core #(.WARPS(WARPS), .THREADS(THREADS)) uut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cfg        (cfg),
        .done       (done),
        .imem_valid (imem_valid),
        .imem_addr  (imem_addr),
        .imem_ready (imem_ready),
        .imem_data  (imem_data),
        .stores     (stores)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic instr_t fetch_word(input imem_addr_t addr);
        if (int'(addr) < PROG_WORDS) begin
            return PROGRAM[int'(addr)];
        end
        return instr_t'({OP_FINISH, 28'd0});
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    //////////////////////////////////////////////////
    // memory models
    //////////////////////////////////////////////////

    // answer each fetch after 0 to 3 cycles
    always @(posedge clk) begin
        imem_ready <= 1'b0;
        if (imem_valid && !imem_ready) begin
            if (delay_left < 0) begin
                rng_state = xorshift32(rng_state);
                delay_left = int'(rng_state[1:0]);
            end
            if (delay_left == 0) begin
                imem_ready <= 1'b1;
                imem_data  <= fetch_word(imem_addr);
                delay_left = -1;
            end else begin
                delay_left = delay_left - 1;
            end
        end
    end

    // the fetch request drops in the cycle after its ready pulse
    always @(negedge clk) begin
        if (ready_seen) begin
            assert (!imem_valid)
                else report_failure("fetch request stayed high after the ready pulse");
        end
        ready_seen = imem_ready;
    end

    // a launch starts an empty data memory
    always @(posedge clk) begin
        if (start) begin
            dmem.delete();
            store_count = 0;
        end
        for (int t = 0; t < THREADS; t++) begin
            if (stores[t].valid) begin
                dmem[stores[t].addr] = stores[t].data;
                store_count = store_count + 1;
            end
        end
    end

    task automatic launch(input test_t test);
        @(posedge clk);
        start <= 1'b1;
        cfg   <= '{num_warps: test.num_warps, base_addr: test.base};
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic check_memory(input test_t test);
        exp_word_t e;
        for (int i = 0; i < int'(test.count); i++) begin
            e = EXPECTED[int'(test.first) + i];
            assert (dmem.exists(e.addr))
                else report_failure($sformatf("no store seen at address %h", e.addr));
            assert (dmem[e.addr] == e.data)
                else report_failure($sformatf("mismatch at %0t: address %h holds %h, expected %h",
                                              $time, e.addr, dmem[e.addr], e.data));
        end
        assert (store_count == int'(test.count))
            else report_failure($sformatf("%0d stores seen where %0d were expected",
                                          store_count, test.count));
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(negedge clk);
        assert (!done) else report_failure("done went high before any start");
        for (int t = 0; t < NUM_TESTS; t++) begin
            launch(TESTS[t]);
            @(negedge clk);
            assert (!done) else report_failure("done did not clear after start");
            while (!done) begin
                @(negedge clk);
            end
            @(negedge clk);
            check_memory(TESTS[t]);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // generous per-kernel budget
    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        report_failure("watchdog expired before all kernels finished");
    end

endmodule

//--- simt_core.f
+incdir+bench
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/warp_scheduler.sv
verilog/instr_decoder.sv
verilog/thread_lane.sv
verilog/lane_collector.sv
verilog/simt_core.sv
bench/simt_core_tb.sv

//--- Makefile
BIN := obj_dir/Vsimt_core_tb

all: run

$(BIN): simt_core.f $(wildcard verilog/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
	verilator --binary --timing --assert -f simt_core.f --top-module simt_core_tb -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: all run clean
